/* build.f */
+incdir+.
hdl/cache_pkg.sv
hdl/fill_if.sv
hdl/cache_array.sv
hdl/way_match.sv
hdl/victim_select.sv
hdl/miss_control.sv
hdl/dcache_top.sv
test/mem_model.sv
test/dcache_tb.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - include_dirs:
      - .
    files:
      - hdl/cache_pkg.sv
      - hdl/fill_if.sv
      - hdl/cache_array.sv
      - hdl/way_match.sv
      - hdl/victim_select.sv
      - hdl/miss_control.sv
      - hdl/dcache_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - test/mem_model.sv
      - test/dcache_tb.sv

/* test/dcache_tb.sv */
// testbench for the data cache, drives requests against a reference model and checks by assertions
`timescale 1ns/1ns
`include "cache_defines.svh"

module dcache_tb;

	// request budget per test
	localparam int BASIC_REQS = 12;
	localparam int WRITE_REQS = 5;
	localparam int EVICT_REQS = 10;
	localparam int RAND_REQS  = 60;
	localparam int REQ_CYCLES = 60;
	localparam int CYCLE_LIMIT =
		REQ_CYCLES * (BASIC_REQS + WRITE_REQS + EVICT_REQS + RAND_REQS) + 8;
	localparam int EVICT_ORDER [EVICT_REQS] = '{0, 1, 2, 3, 4, 0, 2, 1, 3, 4};

	logic clock;
	logic reset;
	logic proc_req;
	logic proc_write;
	cache_pkg::addr_t proc_addr;
	cache_pkg::word_t proc_wdata;
	logic proc_resp;
	cache_pkg::word_t proc_rdata;
	logic proc_hit;
	logic mem_req;
	logic mem_write;
	cache_pkg::addr_t mem_addr;
	cache_pkg::word_t mem_wdata;
	logic mem_resp;
	cache_pkg::word_t mem_rdata;

	// expectation for the request in flight
	logic exp_write;
	logic exp_hit;
	cache_pkg::word_t exp_rdata;
	string test_name;

	// reference cache state
	logic ref_valid [`NUM_SETS][`NUM_WAYS];
	cache_pkg::tag_t ref_tag [`NUM_SETS][`NUM_WAYS];
	cache_pkg::way_t ref_ptr [`NUM_SETS];

	int errors;
	int tests;
	int req_count;
	int resp_count;
	int test_reqs;
	int test_errs;
	int cycles;
	integer seed;
	logic outstanding;

	dcache_top UUT (.*);

	mem_model mem (
		.clock     (clock),
		.mem_req   (mem_req),
		.mem_write (mem_write),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_resp  (mem_resp),
		.mem_rdata (mem_rdata)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// run limit from the request budget
	initial begin
		cycles = 0;
		while (cycles <= CYCLE_LIMIT) begin
			@(posedge clock);
			cycles++;
		end
		$display("timeout, run went past %0d cycles", CYCLE_LIMIT);
		$display("Errors found");
		$finish;
	end

	// one request open at a time
	always @(posedge clock) begin
		if (reset) begin
			outstanding <= 1'b0;
			resp_count  <= 0;
		end else if (proc_resp) begin
			outstanding <= 1'b0;
			resp_count  <= resp_count + 1;
		end else if (proc_req) begin
			outstanding <= 1'b1;
		end
	end

	// read data against the expected memory
	rdata_a: assert property (@(posedge clock) disable iff (reset)
		proc_resp && !exp_write |-> proc_rdata == exp_rdata)
		else begin
			errors++;
			$display("MISMATCH %s rdata expected %h actual %h", test_name, exp_rdata,
				$sampled(proc_rdata));
		end

	hit_a: assert property (@(posedge clock) disable iff (reset)
		proc_resp |-> proc_hit == exp_hit)
		else begin
			errors++;
			$display("MISMATCH %s hit expected %b actual %b", test_name, exp_hit,
				$sampled(proc_hit));
		end

	// response answers an open request and lasts one cycle
	resp_owned_a: assert property (@(posedge clock) disable iff (reset)
		proc_resp |-> outstanding)
		else begin
			errors++;
			$display("proc_resp without an open request in test %s", test_name);
		end

	resp_pulse_a: assert property (@(posedge clock) disable iff (reset)
		proc_resp |=> !proc_resp)
		else begin
			errors++;
			$display("proc_resp stayed high past one cycle in test %s", test_name);
		end

	// hit if a valid way holds the tag
	function automatic logic predict_hit(input cache_pkg::addr_t a);
		cache_pkg::set_idx_t s;
		cache_pkg::tag_t t;
		logic found;
		s = a[`SET_BITS-1:0];
		t = a[`ADDR_BITS-1:`SET_BITS];
		found = 1'b0;
		for (int w = 0; w < `NUM_WAYS; w++) begin
			if (ref_valid[s][w] && ref_tag[s][w] == t) begin
				found = 1'b1;
			end
		end
		return found;
	endfunction

	// miss fill, first invalid way else the pointer, pointer moves every time
	task automatic allocate_line(input cache_pkg::addr_t a);
		cache_pkg::set_idx_t s;
		cache_pkg::way_t v;
		logic found;
		s = a[`SET_BITS-1:0];
		v = ref_ptr[s];
		found = 1'b0;
		for (int w = 0; w < `NUM_WAYS; w++) begin
			if (!found && !ref_valid[s][w]) begin
				v = cache_pkg::way_t'(w);
				found = 1'b1;
			end
		end
		ref_valid[s][v] = 1'b1;
		ref_tag[s][v] = a[`ADDR_BITS-1:`SET_BITS];
		ref_ptr[s] = ref_ptr[s] + 1'b1;
	endtask

	// one request, called on a falling edge, returns a cycle after the response
	task automatic access(input logic wr, input cache_pkg::addr_t a, input cache_pkg::word_t d);
		int n;
		exp_write = wr;
		exp_hit   = predict_hit(a);
		exp_rdata = mem.ref_mem[a];
		if (wr) begin
			// write through, no allocate
			mem.ref_mem[a] = d;
		end else if (!exp_hit) begin
			allocate_line(a);
		end
		proc_req   = 1'b1;
		proc_write = wr;
		proc_addr  = a;
		proc_wdata = d;
		req_count++;
		@(negedge clock);
		proc_req = 1'b0;
		n = 0;
		while (!proc_resp && n < REQ_CYCLES) begin
			@(negedge clock);
			n++;
		end
		if (!proc_resp) begin
			errors++;
			$display("no response to request at address %h in test %s", a, test_name);
		end
		@(negedge clock);
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_reqs = req_count;
		test_errs = errors;
	endtask

	task automatic end_test();
		tests++;
		$display("test %-10s requests %0d errors %0d", test_name, req_count - test_reqs,
			errors - test_errs);
	endtask

	initial begin
		cache_pkg::addr_t a;
		cache_pkg::word_t d;
		cache_pkg::addr_t basic_addrs [6];
		logic wr;
		int idx;
		proc_req = 1'b0;
		proc_write = 1'b0;
		proc_addr = '0;
		proc_wdata = '0;
		reset = 1'b1;
		exp_write = 1'b0;
		exp_hit = 1'b0;
		exp_rdata = '0;
		errors = 0;
		tests = 0;
		req_count = 0;
		seed = 81;
		basic_addrs = '{16'h0010, 16'h0023, 16'h1234, 16'h7ff8, 16'hbeef, 16'h0001};
		for (int s = 0; s < `NUM_SETS; s++) begin
			ref_ptr[s] = '0;
			for (int w = 0; w < `NUM_WAYS; w++) begin
				ref_valid[s][w] = 1'b0;
				ref_tag[s][w] = '0;
			end
		end
		repeat (4) @(negedge clock);
		reset = 1'b0;
		@(negedge clock);

		// strobes quiet out of reset
		start_test("handshake");
		assert (proc_resp === 1'b0 && mem_req === 1'b0)
			else begin
				errors++;
				$display("proc_resp or mem_req high after reset");
			end
		end_test();

		// miss then hit on the same word
		start_test("basic");
		for (int i = 0; i < BASIC_REQS / 2; i++) begin
			access(1'b0, basic_addrs[i], '0);
			access(1'b0, basic_addrs[i], '0);
		end
		end_test();

		// write hit, read back, memory copy
		start_test("write_hit");
		a = basic_addrs[0];
		d = 64'h0123_4567_89ab_cdef;
		access(1'b1, a, d);
		access(1'b0, a, '0);
		assert (mem.store[a] === d)
			else begin
				errors++;
				$display("MISMATCH %s memory expected %h actual %h", test_name, d, mem.store[a]);
			end
		end_test();

		// write miss leaves the line out
		start_test("write_miss");
		a = 16'h3333;
		access(1'b1, a, 64'hfeed_face_0bad_f00d);
		access(1'b0, a, '0);
		access(1'b0, a, '0);
		end_test();

		// five tags fighting over set 5
		start_test("evict");
		for (int i = 0; i < EVICT_REQS; i++) begin
			a = {cache_pkg::tag_t'(13'h100 + EVICT_ORDER[i]), 3'd5};
			access(1'b0, a, '0);
		end
		end_test();

		// 40 addresses, five per set, a third writes
		start_test("random");
		for (int i = 0; i < RAND_REQS; i++) begin
			idx = $unsigned($random(seed)) % 40;
			a = 16'h0800 + cache_pkg::addr_t'(idx * 3);
			wr = ($unsigned($random(seed)) % 3) == 0;
			d = {$random(seed), $random(seed)};
			access(wr, a, d);
		end
		end_test();

		assert (resp_count == req_count)
			else begin
				errors++;
				$display("%0d responses for %0d requests", resp_count, req_count);
			end
		$display("%0d tests, %0d requests, %0d responses, %0d errors", tests, req_count,
			resp_count, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* test/mem_model.sv */
// behavioral word memory for the cache testbench, random read latency plus a shared expected copy
`timescale 1ns/1ns
`include "cache_defines.svh"

module mem_model (
	input  logic              clock,
	input  logic              mem_req,
	input  logic              mem_write,
	input  cache_pkg::addr_t  mem_addr,
	input  cache_pkg::word_t  mem_wdata,
	output logic              mem_resp,
	output cache_pkg::word_t  mem_rdata
);

	localparam int DEPTH = 1 << `ADDR_BITS;

	// contents as the cache writes them
	cache_pkg::word_t store [DEPTH];
	// expected contents, updated by the testbench stimulus
	cache_pkg::word_t ref_mem [DEPTH];

	integer seed;
	int wait_cycles;
	cache_pkg::addr_t rd_addr;

	// start pattern, every address bit shows up
	function automatic cache_pkg::word_t pattern(input cache_pkg::addr_t a);
		return {a, ~a, a ^ 16'hc3a5, a[7:0], a[15:8]};
	endfunction

	initial begin
		seed = 81;
		wait_cycles = 0;
		mem_resp = 1'b0;
		mem_rdata = '0;
		for (int a = 0; a < DEPTH; a++) begin
			store[a] = pattern(cache_pkg::addr_t'(a));
			ref_mem[a] = store[a];
		end
	end

	// outputs move on the falling edge
	always @(negedge clock) begin
		mem_resp <= 1'b0;
		if (wait_cycles == 1) begin
			mem_resp  <= 1'b1;
			mem_rdata <= store[rd_addr];
		end
		if (wait_cycles > 0) begin
			wait_cycles <= wait_cycles - 1;
		end
		if (mem_req && mem_write) begin
			// posted write, no response
			store[mem_addr] <= mem_wdata;
		end else if (mem_req) begin
			rd_addr     <= mem_addr;
			// answer after 1 to 6 cycles
			wait_cycles <= $unsigned($random(seed)) % 6 + 1;
		end
	end

endmodule

/* hdl/dcache_top.sv */
// blocking write-through data cache top, processor port on one side and memory port on the other
`timescale 1ns/1ns
`include "cache_defines.svh"

module dcache_top (
	input  logic              clock,
	input  logic              reset,
	// processor side
	input  logic              proc_req,
	input  logic              proc_write,
	input  cache_pkg::addr_t  proc_addr,
	input  cache_pkg::word_t  proc_wdata,
	output logic              proc_resp,
	output cache_pkg::word_t  proc_rdata,
	output logic              proc_hit,
	// memory side
	output logic              mem_req,
	output logic              mem_write,
	output cache_pkg::addr_t  mem_addr,
	output cache_pkg::word_t  mem_wdata,
	input  logic              mem_resp,
	input  cache_pkg::word_t  mem_rdata
);

	// line update bus
	fill_if upd_bus ();

	// lookup path
	cache_pkg::set_idx_t              lookup_set;
	cache_pkg::tag_t                  lookup_tag;
	cache_pkg::tag_t [`NUM_WAYS-1:0]  set_tags;
	cache_pkg::way_vec_t              set_valids;
	cache_pkg::word_t                 rd_data;
	logic                             hit;
	cache_pkg::way_t                  hit_way;
	// replacement
	cache_pkg::way_t                  victim_way;
	logic                             alloc;

	miss_control ctrl (
		.clock      (clock),
		.reset      (reset),
		.proc_req   (proc_req),
		.proc_write (proc_write),
		.proc_addr  (proc_addr),
		.proc_wdata (proc_wdata),
		.hit        (hit),
		.hit_way    (hit_way),
		.victim_way (victim_way),
		.rd_data    (rd_data),
		.mem_resp   (mem_resp),
		.mem_rdata  (mem_rdata),
		.lookup_set (lookup_set),
		.lookup_tag (lookup_tag),
		.alloc      (alloc),
		.proc_resp  (proc_resp),
		.proc_rdata (proc_rdata),
		.proc_hit   (proc_hit),
		.mem_req    (mem_req),
		.mem_write  (mem_write),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.upd        (upd_bus.ctrl)
	);

	// data word read out at the hit way
	cache_array array (
		.clock      (clock),
		.reset      (reset),
		.rd_set     (lookup_set),
		.rd_way     (hit_way),
		.upd        (upd_bus.array),
		.set_tags   (set_tags),
		.set_valids (set_valids),
		.rd_data    (rd_data)
	);

	way_match match (
		.req_tag    (lookup_tag),
		.set_tags   (set_tags),
		.set_valids (set_valids),
		.hit        (hit),
		.hit_way    (hit_way)
	);

	victim_select victim (
		.clock      (clock),
		.reset      (reset),
		.set        (lookup_set),
		.set_valids (set_valids),
		.alloc      (alloc),
		.upd        (upd_bus.victim),
		.victim_way (victim_way)
	);

endmodule

/* hdl/miss_control.sv */
// cache controller FSM: takes requests, resolves hit or miss, talks to memory and drives fills
`timescale 1ns/1ns
`include "cache_defines.svh"

module miss_control (
	input  logic                 clock,
	input  logic                 reset,
	// processor request
	input  logic                 proc_req,
	input  logic                 proc_write,
	input  cache_pkg::addr_t     proc_addr,
	input  cache_pkg::word_t     proc_wdata,
	// lookup results
	input  logic                 hit,
	input  cache_pkg::way_t      hit_way,
	input  cache_pkg::way_t      victim_way,
	input  cache_pkg::word_t     rd_data,
	// memory read return
	input  logic                 mem_resp,
	input  cache_pkg::word_t     mem_rdata,
	// lookup address toward the array
	output cache_pkg::set_idx_t  lookup_set,
	output cache_pkg::tag_t      lookup_tag,
	// marks a fill as a miss allocation
	output logic                 alloc,
	// processor response
	output logic                 proc_resp,
	output cache_pkg::word_t     proc_rdata,
	output logic                 proc_hit,
	// memory request
	output logic                 mem_req,
	output logic                 mem_write,
	output cache_pkg::addr_t     mem_addr,
	output cache_pkg::word_t     mem_wdata,
	// line update
	fill_if.ctrl                 upd
);

	cache_pkg::ctrl_state_t state;

	// registered request
	logic             req_write;
	cache_pkg::addr_t req_addr;
	cache_pkg::word_t req_wdata;

	// able to take a request this cycle
	logic ready;

	// address split, set in the low bits
	assign lookup_set = req_addr[`SET_BITS-1:0];
	assign lookup_tag = req_addr[`ADDR_BITS-1:`SET_BITS];

	// requests only start from IDLE
	assign ready = (state == cache_pkg::IDLE);

	// state and strobes
	always_ff @(posedge clock) begin
		if (reset) begin
			state     <= cache_pkg::IDLE;
			proc_resp <= 1'b0;
			mem_req   <= 1'b0;
			upd.fill  <= 1'b0;
			alloc     <= 1'b0;
		end else begin
			// strobes last one cycle
			proc_resp <= 1'b0;
			mem_req   <= 1'b0;
			upd.fill  <= 1'b0;
			alloc     <= 1'b0;
			case (state)
				cache_pkg::IDLE: begin
					if (proc_req) begin
						state <= cache_pkg::LOOKUP;
					end
				end
				cache_pkg::LOOKUP: begin
					if (req_write) begin
						// write through, answer at once
						// hit also refreshes the cached copy
						proc_resp <= 1'b1;
						mem_req   <= 1'b1;
						upd.fill  <= hit;
						state     <= cache_pkg::IDLE;
					end else if (hit) begin
						proc_resp <= 1'b1;
						state     <= cache_pkg::IDLE;
					end else begin
						// read miss, fetch the word
						mem_req <= 1'b1;
						state   <= cache_pkg::MISS_WAIT;
					end
				end
				cache_pkg::MISS_WAIT: begin
					if (mem_resp) begin
						proc_resp <= 1'b1;
						upd.fill  <= 1'b1;
						alloc     <= 1'b1;
						state     <= cache_pkg::FILL;
					end
				end
				cache_pkg::FILL: begin
					// line lands at this edge
					state <= cache_pkg::IDLE;
				end
				default: begin
					state <= cache_pkg::IDLE;
				end
			endcase
		end
	end

	// request capture and payload
	always_ff @(posedge clock) begin
		if (ready && proc_req) begin
			req_write <= proc_write;
			req_addr  <= proc_addr;
			req_wdata <= proc_wdata;
		end
		case (state)
			cache_pkg::LOOKUP: begin
				// response and memory fields for hit and write paths
				proc_rdata <= rd_data;
				proc_hit   <= hit;
				mem_write  <= req_write;
				mem_addr   <= req_addr;
				mem_wdata  <= req_wdata;
				// write hit updates the matching way
				upd.set    <= lookup_set;
				upd.way    <= hit_way;
				upd.tag    <= lookup_tag;
				upd.data   <= req_wdata;
			end
			cache_pkg::MISS_WAIT: begin
				if (mem_resp) begin
					proc_rdata <= mem_rdata;
					proc_hit   <= 1'b0;
					// memory word goes into the victim
					upd.set    <= lookup_set;
					upd.way    <= victim_way;
					upd.tag    <= lookup_tag;
					upd.data   <= mem_rdata;
				end
			end
			default: begin
			end
		endcase
	end

	// requester waits for each response before the next request
	req_when_ready_a: assert property (
		@(posedge clock) disable iff (reset)
		proc_req |-> ready
	) else $error("proc_req while busy, state=%s", state.name());

	// memory answers only the one outstanding read
	resp_in_wait_a: assert property (
		@(posedge clock) disable iff (reset)
		mem_resp |-> (state == cache_pkg::MISS_WAIT)
	) else $error("mem_resp outside MISS_WAIT, state=%s", state.name());

endmodule

/* hdl/victim_select.sv */
// replacement choice for a miss, first invalid way or else a per-set round-robin pointer
`timescale 1ns/1ns
`include "cache_defines.svh"

module victim_select (
	input  logic                 clock,
	input  logic                 reset,
	// set under lookup and its valids
	input  cache_pkg::set_idx_t  set,
	input  cache_pkg::way_vec_t  set_valids,
	// fill is a miss allocation
	input  logic                 alloc,
	fill_if.victim               upd,
	output cache_pkg::way_t      victim_way
);

	// one pointer per set
	cache_pkg::way_t rr_ptr [`NUM_SETS];

	// lowest invalid way
	cache_pkg::way_t free_way;
	logic any_free;

	always_comb begin
		free_way = '0;
		for (int w = `NUM_WAYS - 1; w >= 0; w--) begin
			if (!set_valids[w]) begin
				free_way = cache_pkg::way_t'(w);
			end
		end
	end

	assign any_free = |(~set_valids);

	// full set falls back to the pointer
	assign victim_way = any_free ? free_way : rr_ptr[set];

	// pointer moves on every miss fill, invalid way or not
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int s = 0; s < `NUM_SETS; s++) begin
				rr_ptr[s] <= '0;
			end
		end else if (upd.fill && alloc) begin
			// wraps modulo the way count
			rr_ptr[upd.set] <= rr_ptr[upd.set] + 1'b1;
		end
	end

endmodule

/* hdl/way_match.sv */
// tag compare over the ways of one set, giving the hit flag and the hit way
`timescale 1ns/1ns
`include "cache_defines.svh"

module way_match (
	input  cache_pkg::tag_t                  req_tag,
	input  cache_pkg::tag_t [`NUM_WAYS-1:0]  set_tags,
	input  cache_pkg::way_vec_t              set_valids,
	output logic                             hit,
	output cache_pkg::way_t                  hit_way
);

	// per-way match
	cache_pkg::way_vec_t hits;

	// only valid ways take part
	always_comb begin
		for (int w = 0; w < `NUM_WAYS; w++) begin
			hits[w] = set_valids[w] && (set_tags[w] == req_tag);
		end
	end

	// lowest index wins
	// scan downward so the last assignment is the lowest way
	always_comb begin
		hit_way = '0;
		for (int w = `NUM_WAYS - 1; w >= 0; w--) begin
			if (hits[w]) begin
				hit_way = cache_pkg::way_t'(w);
			end
		end
	end

	assign hit = |hits;

	// allocation never places one tag in two ways of a set
	one_hit_a: assert final ($onehot0(hits))
		else $error("more than one way hits, hits=%b", hits);

endmodule

/* hdl/cache_array.sv */
// data, tag and valid storage for all cache lines, read by set and written by the fill bus
`timescale 1ns/1ns
`include "cache_defines.svh"

module cache_array (
	input  logic                                  clock,
	input  logic                                  reset,
	// lookup side
	input  cache_pkg::set_idx_t                   rd_set,
	input  cache_pkg::way_t                       rd_way,
	// line writes
	fill_if.array                                 upd,
	// whole set for the tag compare
	output cache_pkg::tag_t [`NUM_WAYS-1:0]       set_tags,
	output cache_pkg::way_vec_t                   set_valids,
	// word of the selected way
	output cache_pkg::word_t                      rd_data
);

	// flat line storage
	cache_pkg::word_t data_mem [`NUM_LINES];
	cache_pkg::tag_t  tag_mem [`NUM_LINES];
	logic [`NUM_LINES-1:0] valid_mem;

	// line being written
	logic [`LINE_BITS-1:0] wr_line;

	// line number of a set and way
	// set times ways plus way, ways being a power of two
	function automatic logic [`LINE_BITS-1:0] line_of(
		input cache_pkg::set_idx_t s,
		input cache_pkg::way_t     w
	);
		return {s, w};
	endfunction

	assign wr_line = line_of(upd.set, upd.way);

	// combinational readout of the indexed set
	always_comb begin
		for (int w = 0; w < `NUM_WAYS; w++) begin
			set_tags[w]   = tag_mem[line_of(rd_set, cache_pkg::way_t'(w))];
			set_valids[w] = valid_mem[line_of(rd_set, cache_pkg::way_t'(w))];
		end
	end

	// hit word, way comes from the tag match
	assign rd_data = data_mem[line_of(rd_set, rd_way)];

	// valid bits
	always_ff @(posedge clock) begin
		if (reset) begin
			valid_mem <= '0;
		end else if (upd.fill) begin
			// a fill always leaves the line valid
			valid_mem[wr_line] <= 1'b1;
		end
	end

	// tag and data written together
	always_ff @(posedge clock) begin
		if (upd.fill) begin
			data_mem[wr_line] <= upd.data;
			tag_mem[wr_line]  <= upd.tag;
		end
	end

	// controller must hand over a real set with every fill
	set_known_a: assert property (
		@(posedge clock) disable iff (reset)
		upd.fill |-> !$isunknown(upd.set)
	) else $error("fill with unknown set");

endmodule

/* hdl/fill_if.sv */
// line update bus from the cache controller to the storage array and the victim selector
`timescale 1ns/1ns
`include "cache_defines.svh"

interface fill_if;

	// write strobe for one line
	logic fill;
	// target line
	cache_pkg::set_idx_t set;
	cache_pkg::way_t way;
	// new contents
	cache_pkg::tag_t tag;
	cache_pkg::word_t data;

	// controller drives every field
	modport ctrl (output fill, set, way, tag, data);

	// storage takes the whole line
	modport array (input fill, set, way, tag, data);

	// pointer update only needs the set
	modport victim (input fill, set);

endinterface

/* hdl/cache_pkg.sv */
// shared types of the data cache, referenced by scoped name from the RTL and the testbench
`include "cache_defines.svh"

package cache_pkg;

	// word address, low bits select the set
	typedef logic [`ADDR_BITS-1:0] addr_t;

	// set number
	typedef logic [`SET_BITS-1:0] set_idx_t;

	// stored tag, upper address bits
	typedef logic [`TAG_BITS-1:0] tag_t;

	// way number inside a set
	typedef logic [`WAY_BITS-1:0] way_t;

	// one flag per way
	typedef logic [`NUM_WAYS-1:0] way_vec_t;

	// cached data word
	typedef logic [`DATA_BITS-1:0] word_t;

	// controller states
	// IDLE waits for a request, LOOKUP checks the tags,
	// MISS_WAIT waits on memory, FILL answers a miss and writes the line
	typedef enum logic [1:0] {
		IDLE,
		LOOKUP,
		MISS_WAIT,
		FILL
	} ctrl_state_t;

endpackage

/* cache_defines.svh */
// cache geometry and width macros, included by every cache RTL file and the testbench
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// set-associative geometry
`define NUM_SETS 8
`define NUM_WAYS 4
`define SET_BITS 3
`define WAY_BITS 2

// flat line storage, set times ways plus way
`define NUM_LINES 32
`define LINE_BITS 5

// word address, set in the low bits and tag above
`define ADDR_BITS 16
`define TAG_BITS 13

// one cached word per line
`define DATA_BITS 64

`endif
